//--- design/dram_cfg_pkg.sv
`default_nettype none

package dram_cfg_pkg;

    // memory geometry
    localparam int ADDR_W = 24;  // burst address {row,bank,col}
    localparam int DATA_W = 128; // one burst of the 4:1 controller

    localparam int COUNT_W = 16; // completion counter for the display

    // queue sizing defaults, overridden from the top level
    localparam int CMD_DEPTH_DEF = 8;
    localparam int TAG_DEPTH_DEF = 4; // max requests in flight

endpackage

`default_nettype wire

//--- design/dram_cmd_pkg.sv
`default_nettype none

package dram_cmd_pkg;

    import dram_cfg_pkg::*;

    // which reader a read belongs to
    typedef enum logic {
        DEST_AUDIO = 1'b0,
        DEST_VIDEO = 1'b1
    } dest_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        dest_e             dest;
    } read_req_t;

    // queued command, write or read
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data; // don't care on reads
        dest_e             dest; // don't care on writes
    } mem_cmd_t;

    // kept per request until its ack
    typedef struct packed {
        logic  we;
        dest_e dest;
    } issue_tag_t;

    // pipelined memory port request
    typedef struct packed {
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_req_t;

endpackage

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire  clk_dram_ctrl,
    input  wire  rst_dram_ctrl,
    input  wire  i_push,
    input  wire  T i_data,
    input  wire  i_pop,
    output T     o_data,
    output logic o_empty,
    output logic o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push & ~o_full; // push into a full fifo is lost
    assign do_pop  = i_pop & ~o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_data  = mem[rd_ptr]; // head always visible

    always_ff @(posedge clk_dram_ctrl) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/dram_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_decoder #(
    parameter int CMD_DEPTH = dram_cfg_pkg::CMD_DEPTH_DEF
) (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,
    input  wire                              i_wr_valid,
    input  wire  [dram_cfg_pkg::DATA_W-1:0]  i_wr_data,
    input  wire                              i_wr_last,
    input  wire                              i_rd_valid,
    input  wire  dram_cmd_pkg::read_req_t    i_rd_req,
    input  wire                              i_pop,
    output dram_cmd_pkg::mem_cmd_t           o_cmd,
    output logic                             o_cmd_valid,
    output logic                             o_load_complete,
    output logic                             o_overflow
);

    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;

    logic [ADDR_W-1:0] wr_addr; // next burst address of the sample load
    logic              wr_keep;
    logic              rd_keep;
    logic              cmd_push;
    mem_cmd_t          cmd_new;
    logic              cmd_empty;
    logic              cmd_full;

    // loading phase takes writes only, afterwards reads only
    assign wr_keep  = i_wr_valid & ~o_load_complete;
    assign rd_keep  = i_rd_valid & o_load_complete;
    assign cmd_push = wr_keep | rd_keep;

    always_comb begin
        cmd_new = '0;
        if (wr_keep) begin
            cmd_new.we   = 1'b1;
            cmd_new.addr = wr_addr;
            cmd_new.data = i_wr_data;
            cmd_new.dest = DEST_AUDIO; // unused for writes
        end else begin
            cmd_new.we   = 1'b0;
            cmd_new.addr = i_rd_req.addr;
            cmd_new.dest = i_rd_req.dest;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_addr         <= '0;
            o_load_complete <= 1'b0;
            o_overflow      <= 1'b0;
        end else begin
            if (wr_keep) begin
                wr_addr <= wr_addr + 1'b1;
                if (i_wr_last) begin
                    o_load_complete <= 1'b1; // stays set until reset
                end
            end
            if (cmd_push && cmd_full) begin
                o_overflow <= 1'b1; // sticky
            end
        end
    end

    sync_fifo #(
        .T     (mem_cmd_t),
        .DEPTH (CMD_DEPTH)
    ) u_cmd_fifo (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_push        (cmd_push),
        .i_data        (cmd_new),
        .i_pop         (i_pop),
        .o_data        (o_cmd),
        .o_empty       (cmd_empty),
        .o_full        (cmd_full)
    );

    assign o_cmd_valid = ~cmd_empty;

endmodule

`default_nettype wire

//--- design/dram_issue_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dram_issue_unit (
    input  wire                            clk_dram_ctrl,
    input  wire                            rst_dram_ctrl,
    input  wire  dram_cmd_pkg::mem_cmd_t   i_cmd,
    input  wire                            i_cmd_valid,
    input  wire                            i_tag_room,
    input  wire                            i_mem_stall,
    output logic                           o_pop,
    output dram_cmd_pkg::mem_req_t         o_mem,
    output logic                           o_issued,
    output dram_cmd_pkg::issue_tag_t       o_issued_tag
);

    import dram_cmd_pkg::*;

    mem_cmd_t slot;       // command held on the memory port
    logic     slot_valid;
    logic     accept;

    // fill only an empty slot, and only with a free tag entry
    assign o_pop  = i_cmd_valid & i_tag_room & ~slot_valid;
    assign accept = slot_valid & ~i_mem_stall;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            slot_valid <= 1'b0;
        end else if (o_pop) begin
            slot_valid <= 1'b1;
        end else if (accept) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (o_pop) begin
            slot <= i_cmd;
        end
    end

    // held unchanged while stalled
    assign o_mem.stb  = slot_valid;
    assign o_mem.we   = slot.we;
    assign o_mem.addr = slot.addr;
    assign o_mem.data = slot.data;

    assign o_issued          = accept;
    assign o_issued_tag.we   = slot.we;
    assign o_issued_tag.dest = slot.dest;

endmodule

`default_nettype wire

//--- design/dram_response_router.sv
`timescale 1ns/1ps
`default_nettype none

module dram_response_router #(
    parameter int TAG_DEPTH = dram_cfg_pkg::TAG_DEPTH_DEF
) (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,
    input  wire                              i_issued,
    input  wire  dram_cmd_pkg::issue_tag_t   i_issued_tag,
    input  wire                              i_mem_ack,
    input  wire  [dram_cfg_pkg::DATA_W-1:0]  i_mem_rdata,
    output logic                             o_tag_room,
    output logic                             o_audio_valid,
    output logic [dram_cfg_pkg::DATA_W-1:0]  o_audio_data,
    output logic                             o_video_valid,
    output logic [dram_cfg_pkg::DATA_W-1:0]  o_video_data,
    output logic [dram_cfg_pkg::COUNT_W-1:0] o_complete_count
);

    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;

    issue_tag_t head_tag; // oldest request still waiting for its ack
    logic       tag_empty;
    logic       tag_full;
    logic       ack_hit;
    logic       to_audio;
    logic       to_video;

    sync_fifo #(
        .T     (issue_tag_t),
        .DEPTH (TAG_DEPTH)
    ) u_tag_fifo (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_push        (i_issued),
        .i_data        (i_issued_tag),
        .i_pop         (i_mem_ack),
        .o_data        (head_tag),
        .o_empty       (tag_empty),
        .o_full        (tag_full)
    );

    assign o_tag_room = ~tag_full;

    // acks are in order, so the head tag owns this ack
    assign ack_hit  = i_mem_ack & ~tag_empty;
    assign to_audio = ack_hit & ~head_tag.we & (head_tag.dest == DEST_AUDIO);
    assign to_video = ack_hit & ~head_tag.we & (head_tag.dest == DEST_VIDEO);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_audio_valid    <= 1'b0;
            o_video_valid    <= 1'b0;
            o_complete_count <= '0;
        end else begin
            o_audio_valid <= to_audio;
            o_video_valid <= to_video;
            if (i_mem_ack) begin
                o_complete_count <= o_complete_count + 1'b1; // wraps
            end
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (to_audio) begin
            o_audio_data <= i_mem_rdata;
        end
        if (to_video) begin
            o_video_data <= i_mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- design/dram_traffic_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_traffic_top #(
    parameter int CMD_DEPTH = dram_cfg_pkg::CMD_DEPTH_DEF,
    parameter int TAG_DEPTH = dram_cfg_pkg::TAG_DEPTH_DEF
) (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,

    // sample load
    input  wire                              i_wr_valid,
    input  wire  [dram_cfg_pkg::DATA_W-1:0]  i_wr_data,
    input  wire                              i_wr_last,

    // tagged read requests
    input  wire                              i_rd_valid,
    input  wire  dram_cmd_pkg::read_req_t    i_rd_req,

    output logic                             o_audio_valid,
    output logic [dram_cfg_pkg::DATA_W-1:0]  o_audio_data,
    output logic                             o_video_valid,
    output logic [dram_cfg_pkg::DATA_W-1:0]  o_video_data,

    output logic                             o_load_complete,
    output logic                             o_overflow,
    output logic [dram_cfg_pkg::COUNT_W-1:0] o_complete_count,

    // pipelined memory port
    output dram_cmd_pkg::mem_req_t           o_mem,
    input  wire                              i_mem_stall,
    input  wire                              i_mem_ack,
    input  wire  [dram_cfg_pkg::DATA_W-1:0]  i_mem_rdata
);

    import dram_cmd_pkg::*;

    mem_cmd_t   head_cmd;
    logic       head_valid;
    logic       cmd_pop;
    logic       issued;
    issue_tag_t issued_tag;
    logic       tag_room;

    dram_cmd_decoder #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_decoder (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_valid      (i_wr_valid),
        .i_wr_data       (i_wr_data),
        .i_wr_last       (i_wr_last),
        .i_rd_valid      (i_rd_valid),
        .i_rd_req        (i_rd_req),
        .i_pop           (cmd_pop),
        .o_cmd           (head_cmd),
        .o_cmd_valid     (head_valid),
        .o_load_complete (o_load_complete),
        .o_overflow      (o_overflow)
    );

    dram_issue_unit u_issue (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_cmd         (head_cmd),
        .i_cmd_valid   (head_valid),
        .i_tag_room    (tag_room),
        .i_mem_stall   (i_mem_stall),
        .o_pop         (cmd_pop),
        .o_mem         (o_mem),
        .o_issued      (issued),
        .o_issued_tag  (issued_tag)
    );

    dram_response_router #(
        .TAG_DEPTH (TAG_DEPTH)
    ) u_router (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_issued         (issued),
        .i_issued_tag     (issued_tag),
        .i_mem_ack        (i_mem_ack),
        .i_mem_rdata      (i_mem_rdata),
        .o_tag_room       (tag_room),
        .o_audio_valid    (o_audio_valid),
        .o_audio_data     (o_audio_data),
        .o_video_valid    (o_video_valid),
        .o_video_data     (o_video_data),
        .o_complete_count (o_complete_count)
    );

endmodule

`default_nettype wire

//--- verif/dram_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dram_mem_model (
    input  wire                              clk_dram_ctrl,
    input  wire                              rst_dram_ctrl,
    input  wire  dram_cmd_pkg::mem_req_t     i_mem,
    output logic                             o_mem_stall,
    output logic                             o_mem_ack,
    output logic [dram_cfg_pkg::DATA_W-1:0]  o_mem_rdata,
    output int                               o_req_count,
    output int                               o_ack_count
);

    import dram_cfg_pkg::*;

    logic [DATA_W-1:0] store [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] resp_data [$]; // accepted requests, oldest first
    int                resp_due [$];
    integer            seed;
    int                cyc;

    initial begin
        seed        = 49707;
        cyc         = 0;
        o_mem_stall = 1'b0;
        o_mem_ack   = 1'b0;
        o_mem_rdata = '0;
        o_req_count = 0;
        o_ack_count = 0;
    end

    // all port outputs change on the falling edge
    always @(negedge clk_dram_ctrl) begin
        cyc       = cyc + 1;
        o_mem_ack = 1'b0;
        if (rst_dram_ctrl) begin
            o_mem_stall = 1'b0;
        end else begin
            if (resp_due.size() > 0 && resp_due[0] <= cyc) begin
                void'(resp_due.pop_front());
                o_mem_rdata = resp_data.pop_front();
                o_mem_ack   = 1'b1;
                o_ack_count = o_ack_count + 1;
            end
            o_mem_stall = (($random(seed) & 3) == 0); // stall about one cycle in four
            // accepted at the coming rising edge
            if (i_mem.stb && !o_mem_stall) begin
                o_req_count = o_req_count + 1;
                if (i_mem.we) begin
                    store[i_mem.addr] = i_mem.data;
                    resp_data.push_back('0);
                end else if (store.exists(i_mem.addr)) begin
                    resp_data.push_back(store[i_mem.addr]);
                end else begin
                    resp_data.push_back('0);
                end
                resp_due.push_back(cyc + 1 + int'($unsigned($random(seed)) % 4));
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_dram_traffic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dram_traffic;

    import dram_cfg_pkg::*;
    import dram_cmd_pkg::*;

    localparam int CMD_DEPTH = 8;
    localparam int TAG_DEPTH = 2;
    localparam int N_WORDS   = 10;
    localparam int N_READS   = 40;

    logic               clk_dram_ctrl = 1'b0;
    logic               rst_dram_ctrl;
    logic               wr_valid;
    logic [DATA_W-1:0]  wr_data;
    logic               wr_last;
    logic               rd_valid;
    read_req_t          rd_req;
    logic               audio_valid;
    logic [DATA_W-1:0]  audio_data;
    logic               video_valid;
    logic [DATA_W-1:0]  video_data;
    logic               load_complete;
    logic               overflow;
    logic [COUNT_W-1:0] complete_count;
    mem_req_t           mem_req;
    logic               mem_stall;
    logic               mem_ack;
    logic [DATA_W-1:0]  mem_rdata;
    int                 req_count;
    int                 ack_count;

    logic [DATA_W-1:0]  ref_mem [logic [ADDR_W-1:0]]; // expected memory contents
    mem_cmd_t           exp_cmds [$];  // sent but not yet accepted by memory
    mem_cmd_t           in_flight [$]; // accepted, waiting for the ack
    mem_cmd_t           acc_cmd;
    mem_cmd_t           done_cmd;
    logic               exp_audio = 1'b0;
    logic               exp_video = 1'b0;
    logic [DATA_W-1:0]  exp_word = '0;
    logic               load_done = 1'b0;
    int                 load_words = 0;
    int                 sent_count = 0;
    integer             seed;

    always #2 clk_dram_ctrl = ~clk_dram_ctrl;

    dram_traffic_top #(
        .CMD_DEPTH (CMD_DEPTH),
        .TAG_DEPTH (TAG_DEPTH)
    ) u_dram_traffic_top (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_wr_valid       (wr_valid),
        .i_wr_data        (wr_data),
        .i_wr_last        (wr_last),
        .i_rd_valid       (rd_valid),
        .i_rd_req         (rd_req),
        .o_audio_valid    (audio_valid),
        .o_audio_data     (audio_data),
        .o_video_valid    (video_valid),
        .o_video_data     (video_data),
        .o_load_complete  (load_complete),
        .o_overflow       (overflow),
        .o_complete_count (complete_count),
        .o_mem            (mem_req),
        .i_mem_stall      (mem_stall),
        .i_mem_ack        (mem_ack),
        .i_mem_rdata      (mem_rdata)
    );

    dram_mem_model u_mem_model (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_mem         (mem_req),
        .o_mem_stall   (mem_stall),
        .o_mem_ack     (mem_ack),
        .o_mem_rdata   (mem_rdata),
        .o_req_count   (req_count),
        .o_ack_count   (ack_count)
    );

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    // keeps fewer than CMD_DEPTH commands waiting
    task automatic wait_cmd_room;
        int n;
        n = 0;
        while (exp_cmds.size() >= CMD_DEPTH - 1) begin
            @(negedge clk_dram_ctrl);
            n++;
            if (n > 200) abort_run("timed out waiting for queued commands to issue");
        end
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        while (ack_count != sent_count) begin
            @(negedge clk_dram_ctrl);
            n++;
            if (n > 2000) abort_run("timed out waiting for all acknowledges");
        end
        repeat (2) @(negedge clk_dram_ctrl); // let the last read data come out
    endtask

    task automatic send_write(input logic [DATA_W-1:0] data, input logic last);
        mem_cmd_t cmd;
        wait_cmd_room();
        assert (load_complete == load_done)
            else report_mismatch("o_load_complete", DATA_W'(load_complete), DATA_W'(load_done));
        wr_valid = 1'b1;
        wr_data  = data;
        wr_last  = last;
        if (!load_done) begin
            cmd      = '0;
            cmd.we   = 1'b1;
            cmd.addr = ADDR_W'(load_words); // load fills consecutive bursts from 0
            cmd.data = data;
            ref_mem[ADDR_W'(load_words)] = data;
            exp_cmds.push_back(cmd);
            load_words++;
            sent_count++;
        end
        @(negedge clk_dram_ctrl);
        wr_valid = 1'b0;
        wr_last  = 1'b0;
        if (last && !load_done) begin
            load_done = 1'b1;
            assert (load_complete == 1'b1)
                else report_mismatch("o_load_complete", DATA_W'(load_complete), DATA_W'(1));
        end
    endtask

    task automatic send_read(input int addr, input dest_e dest);
        mem_cmd_t cmd;
        wait_cmd_room();
        rd_valid    = 1'b1;
        rd_req.addr = ADDR_W'(addr);
        rd_req.dest = dest;
        if (load_done) begin
            cmd      = '0;
            cmd.addr = ADDR_W'(addr);
            cmd.dest = dest;
            exp_cmds.push_back(cmd);
            sent_count++;
        end
        @(negedge clk_dram_ctrl);
        rd_valid = 1'b0;
    endtask

    // port monitor sampled at the rising edge before any register update
    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl) begin
            assert (audio_valid == exp_audio)
                else report_mismatch("o_audio_valid", DATA_W'(audio_valid), DATA_W'(exp_audio));
            assert (video_valid == exp_video)
                else report_mismatch("o_video_valid", DATA_W'(video_valid), DATA_W'(exp_video));
            if (exp_audio) begin
                assert (audio_data == exp_word)
                    else report_mismatch("o_audio_data", audio_data, exp_word);
            end
            if (exp_video) begin
                assert (video_data == exp_word)
                    else report_mismatch("o_video_data", video_data, exp_word);
            end
            // acks of earlier cycles only, this one counts after the edge
            assert (complete_count == COUNT_W'(ack_count - int'(mem_ack)))
                else report_mismatch("o_complete_count", DATA_W'(complete_count),
                                     DATA_W'(ack_count - int'(mem_ack)));
            exp_audio = 1'b0;
            exp_video = 1'b0;
            if (mem_ack) begin
                assert (in_flight.size() > 0)
                    else abort_run("memory acknowledge with no request in flight");
                done_cmd = in_flight.pop_front();
                if (!done_cmd.we) begin // read data due on the next cycle
                    exp_word  = ref_mem[done_cmd.addr];
                    exp_audio = (done_cmd.dest == DEST_AUDIO);
                    exp_video = (done_cmd.dest == DEST_VIDEO);
                end
            end
            if (mem_req.stb && !mem_stall) begin
                assert (exp_cmds.size() > 0)
                    else abort_run("memory request that matches no sent command");
                acc_cmd = exp_cmds.pop_front();
                assert (mem_req.we == acc_cmd.we)
                    else report_mismatch("o_mem.we", DATA_W'(mem_req.we), DATA_W'(acc_cmd.we));
                assert (mem_req.addr == acc_cmd.addr)
                    else report_mismatch("o_mem.addr", DATA_W'(mem_req.addr),
                                         DATA_W'(acc_cmd.addr));
                if (acc_cmd.we) begin
                    assert (mem_req.data == acc_cmd.data)
                        else report_mismatch("o_mem.data", mem_req.data, acc_cmd.data);
                end
                in_flight.push_back(acc_cmd);
            end
            assert (in_flight.size() <= TAG_DEPTH)
                else abort_run("more requests in flight than the tag limit allows");
        end
    end

    initial begin
        int rnd;
        int gap;
        seed          = 49707;
        rst_dram_ctrl = 1'b1;
        wr_valid      = 1'b0;
        wr_data       = '0;
        wr_last       = 1'b0;
        rd_valid      = 1'b0;
        rd_req        = '0;
        repeat (4) @(negedge clk_dram_ctrl);
        rst_dram_ctrl = 1'b0;
        @(negedge clk_dram_ctrl);

        send_read(3, DEST_VIDEO); // too early as the load is still open
        for (int i = 0; i < N_WORDS; i++) begin
            send_write({$random(seed), $random(seed), $random(seed), $random(seed)},
                       i == N_WORDS - 1);
            @(negedge clk_dram_ctrl);
        end
        send_write({4{32'hdead_beef}}, 1'b0); // dropped since the load is closed

        for (int i = 0; i < N_READS; i++) begin
            rnd = $random(seed);
            send_read(int'($unsigned($random(seed)) % N_WORDS), dest_e'(rnd[0]));
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) @(negedge clk_dram_ctrl);
        end
        wait_drain();

        assert (req_count == sent_count)
            else report_mismatch("memory request count", DATA_W'(req_count), DATA_W'(sent_count));
        assert (complete_count == COUNT_W'(ack_count))
            else report_mismatch("o_complete_count", DATA_W'(complete_count),
                                 DATA_W'(ack_count));
        assert (overflow == 1'b0)
            else report_mismatch("o_overflow", DATA_W'(overflow), DATA_W'(0));
        assert (exp_cmds.size() == 0 && in_flight.size() == 0)
            else abort_run("commands were left without an acknowledge");
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- drum_dram_traffic.f
design/dram_cfg_pkg.sv
design/dram_cmd_pkg.sv
design/sync_fifo.sv
design/dram_cmd_decoder.sv
design/dram_issue_unit.sv
design/dram_response_router.sv
design/dram_traffic_top.sv
verif/dram_mem_model.sv
verif/tb_dram_traffic.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_dram_traffic -f drum_dram_traffic.f
	@out=$$(./obj_dir/Vtb_dram_traffic 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
